// File: project.f
logic/mouse_pkg.sv
logic/bound_set_if.sv
logic/move_if.sv
logic/bounds_loader.sv
logic/packet_decoder.sv
logic/position_tracker.sv
logic/mouse_bounds_top.sv
verification/mouse_bounds_tb.sv

// File: verification/mouse_testdata.txt
# Hex fields: T test | B byte | G | M | W busy_cycles | C xpos ypos left right
T 1
W 0
C 000 000 0 0
B 18
B F0
B 10
C 000 000 0 0
T 2
B 29
B 64
B CE
C 064 032 1 0
B 1A
B E2
B 14
C 046 01E 0 1
B 28
B FF
B 01
B 28
B FF
B 01
B 28
B FF
B 01
B 2B
B FF
B 01
C 3FB 2FB 1 1
T 3
G
W 4
C 320 258 1 1
B 18
B 01
B FF
C 221 159 0 0
B 18
B 01
B FF
B 18
B 01
B FF
C 0C8 0C8 0 0
T 4
M
W 4
B 18
B 01
B FF
C 000 000 0 0
M
G
W 3
C 000 000 0 0
T 5
B 04
B 29
B 10
B F8
C 010 008 1 0
B 68
B 50
B E0
C 010 028 0 0
B 88
B 20
B 40
C 030 028 0 0

// File: verification/mouse_bounds_tb.sv
`timescale 1ns/1ns

module mouse_bounds_tb
    import mouse_pkg::*;
();

    logic       clk;
    logic       rst;
    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       game_req;
    logic       menu_req;
    coord_t     xpos;
    coord_t     ypos;
    logic       left_btn;
    logic       right_btn;
    logic       bounds_loading;

    int         fd;
    int         pass_count;
    int         fail_count;
    int         test_num;
    int         test_errors;
    bit         test_open;
    bit         aborted;
    // Rectangle the cursor should be in once the loader is idle
    bit         game_mode;
    // Rising edges so far and the edge of the last accepted request
    int         cycle_count;
    int         last_accept;

    mouse_bounds_top uut (
        .clk            (clk),
        .rst            (rst),
        .rx_byte        (rx_byte),
        .rx_valid       (rx_valid),
        .game_req       (game_req),
        .menu_req       (menu_req),
        .xpos           (xpos),
        .ypos           (ypos),
        .left_btn       (left_btn),
        .right_btn      (right_btn),
        .bounds_loading (bounds_loading)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic check_value(input string name, input logic [11:0] exp, input logic [11:0] got);
        assert (got === exp) begin
            pass_count++;
        end else begin
            $display("[ERROR] %s expected %h got %h", name, exp, got);
            fail_count++;
            test_errors++;
        end
    endtask

    function automatic bit inside_rect(input coord_t x, input coord_t y, input bit game);
        if (game) begin
            return x >= GAME_MIN_X && x <= GAME_MAX_X && y >= GAME_MIN_Y && y <= GAME_MAX_Y;
        end
        return x >= MENU_MIN_X && x <= MENU_MAX_X && y >= MENU_MIN_Y && y <= MENU_MAX_Y;
    endfunction

    task automatic check_position(input logic [11:0] ex, input logic [11:0] ey,
                                  input logic [11:0] el, input logic [11:0] er);
        // Longer than the packet and loader latencies
        repeat (3) @(negedge clk);
        check_value("xpos", ex, xpos);
        check_value("ypos", ey, ypos);
        check_value("left_btn", el, {11'd0, left_btn});
        check_value("right_btn", er, {11'd0, right_btn});
        assert (inside_rect(xpos, ypos, game_mode)) begin
            pass_count++;
        end else begin
            $display("Cursor lies outside the rectangle of the active mode");
            fail_count++;
            test_errors++;
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic send_byte(input logic [7:0] b);
        rx_byte  = b;
        rx_valid = 1'b1;
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    task automatic send_request(input bit game);
        int sample_edge;
        // Loader stays busy for four edges after an accepted request
        sample_edge = cycle_count + 1;
        if (sample_edge > last_accept + 4) begin
            game_mode   = game;
            last_accept = sample_edge;
        end
        game_req = game;
        menu_req = !game;
        @(negedge clk);
        game_req = 1'b0;
        menu_req = 1'b0;
    endtask

    task automatic wait_loader_idle(input logic [11:0] exp_busy);
        int busy;
        busy = 0;
        while (bounds_loading && busy < 20) begin
            busy++;
            @(negedge clk);
        end
        if (bounds_loading) begin
            $display("Timeout while waiting for the bounds loader to finish");
            fail_count++;
            test_errors++;
            aborted = 1'b1;
        end else begin
            check_value("bounds_loading cycles", exp_busy, 12'(busy));
        end
    endtask

    task automatic finish_test();
        if (test_open) begin
            if (test_errors == 0) begin
                $display("Test %0d passed", test_num);
            end else begin
                $display("Test %0d failed with %0d errors", test_num, test_errors);
            end
        end
    endtask

    task automatic bad_line();
        $display("Malformed line in the test data file");
        fail_count++;
        aborted = 1'b1;
    endtask

    task automatic run_command(input logic [7:0] letter);
        logic [11:0]      f0;
        logic [11:0]      f1;
        logic [11:0]      f2;
        logic [11:0]      f3;
        logic [8*200-1:0] rest;
        int               code;
        case (letter)
            "#": code = $fgets(rest, fd);
            "T": begin
                code = $fscanf(fd, "%h", f0);
                if (code != 1) begin
                    bad_line();
                end else begin
                    finish_test();
                    test_num    = f0;
                    test_errors = 0;
                    test_open   = 1'b1;
                end
            end
            "B": begin
                code = $fscanf(fd, "%h", f0);
                if (code != 1) bad_line();
                else send_byte(f0[7:0]);
            end
            "G": send_request(1'b1);
            "M": send_request(1'b0);
            "W": begin
                code = $fscanf(fd, "%h", f0);
                if (code != 1) bad_line();
                else wait_loader_idle(f0);
            end
            "C": begin
                code = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                if (code != 4) bad_line();
                else check_position(f0, f1, f2, f3);
            end
            default: bad_line();
        endcase
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        logic [63:0] word;
        int          code;
        bit          file_done;
        clk         = 1'b0;
        rst         = 1'b1;
        rx_byte     = 8'h00;
        rx_valid    = 1'b0;
        game_req    = 1'b0;
        menu_req    = 1'b0;
        pass_count  = 0;
        fail_count  = 0;
        test_num    = 0;
        test_errors = 0;
        test_open   = 1'b0;
        aborted     = 1'b0;
        game_mode   = 1'b0;
        cycle_count = 0;
        last_accept = -100;
        file_done   = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        fd = $fopen("verification/mouse_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            fail_count++;
            aborted = 1'b1;
        end
        while (!aborted && !file_done) begin
            code = $fscanf(fd, "%s", word);
            if (code != 1) file_done = 1'b1;
            else run_command(word[7:0]);
        end
        finish_test();
        if (fd != 0) $fclose(fd);

        $display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: logic/mouse_bounds_top.sv
`timescale 1ns/1ns

module mouse_bounds_top
    import mouse_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] rx_byte,
    input  logic       rx_valid,
    input  logic       game_req,
    input  logic       menu_req,
    output coord_t     xpos,
    output coord_t     ypos,
    output logic       left_btn,
    output logic       right_btn,
    output logic       bounds_loading
);

    //////////////////////////////
    // Internal buses
    //////////////////////////////

    // Loader to tracker limit writes
    bound_set_if bset_bus ();

    // Decoder to tracker movement reports
    move_if      mv_bus ();

    //////////////////////////////
    // Blocks
    //////////////////////////////

    bounds_loader u_loader (
        .clk      (clk),
        .rst      (rst),
        .game_req (game_req),
        .menu_req (menu_req),
        .loading  (bounds_loading),
        .bset     (bset_bus.loader)
    );

    packet_decoder u_decoder (
        .clk      (clk),
        .rst      (rst),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .mv       (mv_bus.decoder)
    );

    position_tracker u_tracker (
        .clk       (clk),
        .rst       (rst),
        .bset      (bset_bus.tracker),
        .mv        (mv_bus.tracker),
        .xpos      (xpos),
        .ypos      (ypos),
        .left_btn  (left_btn),
        .right_btn (right_btn)
    );

endmodule

// File: logic/position_tracker.sv
`timescale 1ns/1ns

module position_tracker
    import mouse_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    bound_set_if.tracker bset,
    move_if.tracker      mv,
    output coord_t       xpos,
    output coord_t       ypos,
    output logic         left_btn,
    output logic         right_btn
);

    // Limit registers
    coord_t max_x;
    coord_t max_y;
    coord_t min_x;
    coord_t min_y;

    // Unclamped sums, wide enough for any coordinate plus a delta
    logic signed [13:0] x_sum;
    logic signed [13:0] y_sum;
    coord_t             x_next;
    coord_t             y_next;
    logic               any_set;

    assign any_set = bset.setmax_x | bset.setmax_y | bset.setmin_x | bset.setmin_y;

    function automatic coord_t clamp(
        input logic signed [13:0] v,
        input coord_t             lo,
        input coord_t             hi
    );
        if (v < $signed({2'b00, lo})) begin
            return lo;
        end else if (v > $signed({2'b00, hi})) begin
            return hi;
        end
        return coord_t'(v[11:0]);
    endfunction

    //////////////////////////////
    // Limit registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            max_x <= MENU_MAX_X;
            max_y <= MENU_MAX_Y;
            min_x <= MENU_MIN_X;
            min_y <= MENU_MIN_Y;
        end else begin
            if (bset.setmax_x) begin
                max_x <= bset.value;
            end
            if (bset.setmax_y) begin
                max_y <= bset.value;
            end
            if (bset.setmin_x) begin
                min_x <= bset.value;
            end
            if (bset.setmin_y) begin
                min_y <= bset.value;
            end
        end
    end

    //////////////////////////////
    // Position update
    //////////////////////////////

    always_comb begin
        if (mv.valid) begin
            // PS/2 Y grows upward, screen Y grows downward
            x_sum = $signed({2'b00, xpos}) + $signed(mv.dx);
            y_sum = $signed({2'b00, ypos}) - $signed(mv.dy);
        end else begin
            // Idle cycle just re-clamps against the current limits
            x_sum = $signed({2'b00, xpos});
            y_sum = $signed({2'b00, ypos});
        end
        x_next = clamp(x_sum, min_x, max_x);
        y_next = clamp(y_sum, min_y, max_y);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            xpos      <= '0;
            ypos      <= '0;
            left_btn  <= 1'b0;
            right_btn <= 1'b0;
        end else begin
            xpos <= x_next;
            ypos <= y_next;
            if (mv.valid) begin
                left_btn  <= mv.left;
                right_btn <= mv.right;
            end
        end
    end

    // Quiet cycle leaves the cursor inside the rectangle
    a_inside_limits: assert property (@(posedge clk) disable iff (rst)
        (!mv.valid && !any_set) |=>
            (xpos >= min_x && xpos <= max_x && ypos >= min_y && ypos <= max_y));

endmodule

// File: logic/packet_decoder.sv
`timescale 1ns/1ns

module packet_decoder
    import mouse_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic [7:0]   rx_byte,
    input  logic         rx_valid,
    move_if.decoder      mv
);

    // Position of the next byte inside the packet
    logic [1:0] byte_cnt;

    // First two bytes held until the packet completes
    logic [7:0] status_byte;
    logic [7:0] x_byte;

    // Status byte fields
    logic       x_sign;
    logic       y_sign;
    logic       x_ovf;
    logic       y_ovf;

    assign x_sign = status_byte[4];
    assign y_sign = status_byte[5];
    assign x_ovf  = status_byte[6];
    assign y_ovf  = status_byte[7];

    //////////////////////////////
    // Byte counter
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt <= 2'd0;
        end else if (rx_valid) begin
            case (byte_cnt)
                2'd0: begin
                    // Bit 3 is always set in a status byte, otherwise resync
                    if (rx_byte[3]) begin
                        byte_cnt <= 2'd1;
                    end
                end
                2'd1: byte_cnt <= 2'd2;
                default: byte_cnt <= 2'd0;
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            if (byte_cnt == 2'd0 && rx_byte[3]) begin
                status_byte <= rx_byte;
            end
            if (byte_cnt == 2'd1) begin
                x_byte <= rx_byte;
            end
        end
    end

    //////////////////////////////
    // Report output
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            mv.valid <= 1'b0;
        end else begin
            mv.valid <= rx_valid && (byte_cnt == 2'd2);
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && byte_cnt == 2'd2) begin
            // Overflowed axis reports no movement
            mv.dx    <= x_ovf ? delta_t'(0) : {x_sign, x_byte};
            mv.dy    <= y_ovf ? delta_t'(0) : {y_sign, rx_byte};
            mv.left  <= status_byte[0];
            mv.right <= status_byte[1];
        end
    end

    // Packets take three strobes, so reports can never be back to back
    a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        mv.valid |=> !mv.valid);

endmodule

// File: logic/bounds_loader.sv
`timescale 1ns/1ns

module bounds_loader
    import mouse_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        game_req,
    input  logic        menu_req,
    output logic        loading,
    bound_set_if.loader bset
);

    loader_state_t state;
    loader_state_t state_nxt;
    logic [1:0]    step;

    //////////////////////////////
    // Sequence state
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LOAD_IDLE;
            step  <= 2'd0;
        end else begin
            state <= state_nxt;
            // Wraps back to zero after the last limit
            if (state != LOAD_IDLE) begin
                step <= step + 2'd1;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            LOAD_IDLE: begin
                // Game request has priority
                if (game_req) begin
                    state_nxt = LOAD_GAME;
                end else if (menu_req) begin
                    state_nxt = LOAD_MENU;
                end
            end
            LOAD_GAME, LOAD_MENU: begin
                if (step == 2'd3) begin
                    state_nxt = LOAD_IDLE;
                end
            end
            default: state_nxt = LOAD_IDLE;
        endcase
    end

    //////////////////////////////
    // Strobes and limit value
    //////////////////////////////

    always_comb begin
        bset.setmax_x = 1'b0;
        bset.setmax_y = 1'b0;
        bset.setmin_x = 1'b0;
        bset.setmin_y = 1'b0;
        bset.value    = '0;
        if (state != LOAD_IDLE) begin
            // Order is max x, max y, min x, min y
            case (step)
                2'd0: begin
                    bset.setmax_x = 1'b1;
                    bset.value    = (state == LOAD_GAME) ? GAME_MAX_X : MENU_MAX_X;
                end
                2'd1: begin
                    bset.setmax_y = 1'b1;
                    bset.value    = (state == LOAD_GAME) ? GAME_MAX_Y : MENU_MAX_Y;
                end
                2'd2: begin
                    bset.setmin_x = 1'b1;
                    bset.value    = (state == LOAD_GAME) ? GAME_MIN_X : MENU_MIN_X;
                end
                default: begin
                    bset.setmin_y = 1'b1;
                    bset.value    = (state == LOAD_GAME) ? GAME_MIN_Y : MENU_MIN_Y;
                end
            endcase
        end
    end

    assign loading = (state != LOAD_IDLE);

    // Tracker relies on a single limit being written per cycle
    a_strobe_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({bset.setmax_x, bset.setmax_y, bset.setmin_x, bset.setmin_y}));

    // No gap in the sequence while it runs
    a_strobe_busy: assert property (@(posedge clk) disable iff (rst)
        (state != LOAD_IDLE) |->
            (bset.setmax_x || bset.setmax_y || bset.setmin_x || bset.setmin_y));

endmodule

// File: logic/move_if.sv
`timescale 1ns/1ns

interface move_if
    import mouse_pkg::*;
();

    // Single-cycle report strobe
    logic   valid;

    // Deltas and button levels, valid with the strobe only
    delta_t dx;
    delta_t dy;
    logic   left;
    logic   right;

    modport decoder (
        output valid,
        output dx, dy, left, right
    );

    modport tracker (
        input valid,
        input dx, dy, left, right
    );

endinterface

// File: logic/bound_set_if.sv
`timescale 1ns/1ns

interface bound_set_if
    import mouse_pkg::*;
();

    // Limit value, only meaningful while one of the strobes is high
    coord_t value;

    // One strobe per limit register
    logic   setmax_x;
    logic   setmax_y;
    logic   setmin_x;
    logic   setmin_y;

    modport loader (
        output value,
        output setmax_x, setmax_y, setmin_x, setmin_y
    );

    modport tracker (
        input value,
        input setmax_x, setmax_y, setmin_x, setmin_y
    );

endinterface

// File: logic/mouse_pkg.sv
package mouse_pkg;

    //////////////////////////////
    // Types
    //////////////////////////////

    // Screen coordinate, also used for the limit values
    typedef logic [11:0] coord_t;

    // PS/2 movement delta, sign bit joined with the magnitude byte
    typedef logic [8:0] delta_t;

    // Bounds loader sequence
    typedef enum logic [1:0] {
        LOAD_IDLE,
        LOAD_GAME,
        LOAD_MENU
    } loader_state_t;

    //////////////////////////////
    // Mode rectangles
    //////////////////////////////

    // Game area
    localparam coord_t GAME_MAX_X = 12'd800;
    localparam coord_t GAME_MAX_Y = 12'd600;
    localparam coord_t GAME_MIN_X = 12'd200;
    localparam coord_t GAME_MIN_Y = 12'd200;

    // Full menu screen, loaded at reset
    localparam coord_t MENU_MAX_X = 12'd1019;
    localparam coord_t MENU_MAX_Y = 12'd763;
    localparam coord_t MENU_MIN_X = 12'd0;
    localparam coord_t MENU_MIN_Y = 12'd0;

endpackage
